//--- sim.f
common/periph_bus_pkg.sv
design/apb_node/apb_rto_counter.sv
design/apb_node/apb_node.sv
design/periph_bus_wrap.sv
dv/apb_periph_model.sv
dv/tb_periph_bus.sv

//--- Makefile
VERILATOR ?= verilator
TOP       := tb_periph_bus
FILELIST  := sim.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps -j 0 \
             --top-module $(TOP) --Mdir $(OBJ_DIR)
LINTFLAGS := --lint-only --timing --assert --timescale 1ns/1ps --top-module $(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

# the run passes only if the pass message shows up on a line of its own
run: build
	@out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -q "^TEST PASSED$$"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- dv/tb_periph_bus.sv
// *********************************************************************
// peripheral bus testbench
// drives the APB completer port of the top level, models the four
// peripherals and checks decode, data, timing and timeout completion
// *********************************************************************

module tb_periph_bus
  import periph_bus_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned    RTO_CYCLES  = 16;
  localparam int unsigned    READY_LIMIT = 40;
  localparam int unsigned    NB_RANDOM   = 12;
  localparam logic [31:0]    LFSR_SEED   = 32'h6ad66c51;
  localparam int unsigned    WAITS [NB_PERIPH] = '{0, 3, 0, 0};
  localparam int unsigned    LIVE_IDX [3] = '{0, 1, 3};
  localparam logic [NB_PERIPH-1:0] SILENT = 4'b0100;

  logic                 clk;
  logic                 rst;
  apb_req_t             slv_req;
  apb_rsp_t             slv_rsp;
  apb_req_t [NB_PERIPH-1:0] mst_req;
  apb_rsp_t [NB_PERIPH-1:0] mst_rsp;
  logic [NB_PERIPH-1:0] periph_rto;
  logic [NB_PERIPH-1:0] psel_vec;
  logic [NB_PERIPH-1:0] psel_exp;
  logic [NB_PERIPH-1:0] rto_seen;
  logic [31:0]          lfsr_q;
  logic [31:0]          scoreboard [NB_PERIPH][16];
  int                   errors = 0;
  int                   rto_pulses = 0;

  initial clk = 1'b0;
  always #4 clk = ~clk;

  periph_bus_wrap #(
    .RTO_CYCLES (RTO_CYCLES)
  ) DUT (
    .clk_i            (clk),
    .rst_i            (rst),
    .slv_req_i        (slv_req),
    .slv_rsp_o        (slv_rsp),
    .mst_req_o        (mst_req),
    .mst_rsp_i        (mst_rsp),
    .peripheral_rto_o (periph_rto)
  );

  for (genvar k = 0; k < NB_PERIPH; k++) begin : g_periph
    apb_periph_model #(
      .WAIT_STATES (WAITS[k]),
      .NEVER_READY (SILENT[k])
    ) u_model (
      .clk_i (clk),
      .rst_i (rst),
      .req_i (mst_req[k]),
      .rsp_o (mst_rsp[k])
    );
  end

  // *******************************************************************
  // reference decode and bus checks
  // *******************************************************************

  function automatic logic [NB_PERIPH-1:0] window_hits(input logic [31:0] addr);
    logic [NB_PERIPH-1:0] hits;
    hits = '0;
    for (int k = 0; k < NB_PERIPH; k++) begin
      if (addr >= PERIPH_MAP[k].start_addr && addr <= PERIPH_MAP[k].end_addr) begin
        hits[k] = 1'b1;
      end
    end
    return hits;
  endfunction

  always_comb begin
    for (int k = 0; k < NB_PERIPH; k++) begin
      psel_vec[k] = mst_req[k].psel;
    end
    psel_exp = window_hits(slv_req.paddr) & {NB_PERIPH{slv_req.psel}};
  end

  a_psel_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(psel_vec))
    else begin
      errors++;
      $display("Fail psel_onehot: expected at most one psel, actual %b", psel_vec);
    end

  a_psel_decode: assert property (@(posedge clk) disable iff (rst) psel_vec == psel_exp)
    else begin
      errors++;
      $display("Fail psel_decode: expected %b, actual %b", psel_exp, psel_vec);
    end

  // a timeout flag may only show the silent index, in an error completion
  a_rto_flag: assert property (@(posedge clk) disable iff (rst)
      (|periph_rto) |-> (periph_rto == SILENT && slv_rsp.pready && slv_rsp.pslverr))
    else begin
      errors++;
      $display("Fail rto_flag: expected %b with an error completion, actual %b",
               SILENT, periph_rto);
    end

  always @(negedge clk) begin
    if (!rst && |periph_rto) begin
      rto_pulses++;
      rto_seen = periph_rto;
    end
  end

  // *******************************************************************
  // stimulus helpers
  // *******************************************************************

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      val = {val[30:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'hA300_0000) : (lfsr_q >> 1);
    end
    return val;
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    assert (exp == act) else begin
      errors++;
      $display("Fail %s: expected 0x%08h, actual 0x%08h", name, exp, act);
    end
  endtask

  // one APB transfer; cycles counts access cycles up to and including completion
  task automatic apb_transfer(input logic [31:0] addr, input logic write,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err, output int cycles);
    bit done;
    done   = 1'b0;
    rdata  = '0;
    err    = 1'b0;
    cycles = 0;
    @(posedge clk);
    #1;
    slv_req.paddr   = addr;
    slv_req.pwrite  = write;
    slv_req.pwdata  = wdata;
    slv_req.psel    = 1'b1;
    slv_req.penable = 1'b0;
    @(posedge clk);
    #1;
    slv_req.penable = 1'b1;
    while (!done && cycles < READY_LIMIT) begin
      @(negedge clk);
      cycles++;
      if (slv_rsp.pready) begin
        done  = 1'b1;
        rdata = slv_rsp.prdata;
        err   = slv_rsp.pslverr;
      end
    end
    if (!done) begin
      errors++;
      $display("no pready within %0d cycles for address 0x%08h", READY_LIMIT, addr);
    end
    @(posedge clk);
    #1;
    slv_req.psel    = 1'b0;
    slv_req.penable = 1'b0;
  endtask

  task automatic write_and_track(input int unsigned k, input logic [31:0] addr,
                                 input logic [31:0] data);
    logic [31:0] rdata;
    logic        err;
    int          cycles;
    apb_transfer(addr, 1'b1, data, rdata, err, cycles);
    check_value("write_pslverr", 32'd0, 32'(err));
    check_value("write_cycles", WAITS[k] + 1, 32'(cycles));
    scoreboard[k][addr[5:2]] = data;
  endtask

  task automatic read_and_compare(input int unsigned k, input logic [31:0] addr);
    logic [31:0] rdata;
    logic        err;
    int          cycles;
    apb_transfer(addr, 1'b0, '0, rdata, err, cycles);
    check_value("read_data", scoreboard[k][addr[5:2]], rdata);
    check_value("read_pslverr", 32'd0, 32'(err));
    check_value("read_cycles", WAITS[k] + 1, 32'(cycles));
  endtask

  // *******************************************************************
  // test sequence
  // *******************************************************************

  initial begin
    logic [31:0]  addr;
    logic [31:0]  rdata;
    logic         err;
    int           cycles;
    int           pulses_before;
    int unsigned  k;
    logic [31:0]  wr_addr_q [$];
    int unsigned  wr_idx_q [$];

    lfsr_q  = LFSR_SEED;
    rst     = 1'b1;
    slv_req = '0;
    for (int p = 0; p < NB_PERIPH; p++) begin
      for (int w = 0; w < 16; w++) begin
        scoreboard[p][w] = '0;
      end
    end
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;

    // quiet bus before the first transfer
    repeat (3) begin
      @(negedge clk);
      check_value("idle_psel", 32'd0, 32'(psel_vec));
      check_value("idle_rto", 32'd0, 32'(periph_rto));
      check_value("idle_pready", 32'd0, 32'(slv_rsp.pready));
    end

    // rotate over the live peripherals so that each one sees traffic
    for (int i = 0; i < NB_RANDOM; i++) begin
      k    = LIVE_IDX[i % 3];
      addr = PERIPH_MAP[k].start_addr + (rand_bits(10) << 2);
      write_and_track(k, addr, rand_bits(32));
      wr_addr_q.push_back(addr);
      wr_idx_q.push_back(k);
    end
    foreach (wr_addr_q[i]) begin
      read_and_compare(wr_idx_q[i], wr_addr_q[i]);
    end

    // the gap between timer and soc_ctrl belongs to no peripheral
    for (int i = 0; i < 2; i++) begin
      addr          = 32'h1A10_3000 + (rand_bits(10) << 2);
      pulses_before = rto_pulses;
      apb_transfer(addr, (i == 0), rand_bits(32), rdata, err, cycles);
      check_value("unmapped_cycles", 32'd1, 32'(cycles));
      check_value("unmapped_pslverr", 32'd1, 32'(err));
      check_value("unmapped_prdata", 32'd0, rdata);
      check_value("unmapped_rto", 32'(pulses_before), 32'(rto_pulses));
    end

    addr          = PERIPH_MAP[2].start_addr + (rand_bits(10) << 2);
    pulses_before = rto_pulses;
    apb_transfer(addr, 1'b0, '0, rdata, err, cycles);
    check_value("timeout_cycles", RTO_CYCLES, 32'(cycles));
    check_value("timeout_pslverr", 32'd1, 32'(err));
    check_value("timeout_pulses", 32'(pulses_before + 1), 32'(rto_pulses));
    check_value("timeout_index", 32'(SILENT), 32'(rto_seen));

    // a stale counter would cut this transfer short
    addr = PERIPH_MAP[1].start_addr + (rand_bits(10) << 2);
    write_and_track(1, addr, rand_bits(32));
    read_and_compare(1, addr);

    repeat (2) @(posedge clk);
    $display("checks done, errors: %0d, timeout pulses: %0d", errors, rto_pulses);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- dv/apb_periph_model.sv
// *********************************************************************
// APB peripheral model
// 16 words of register storage, a fixed number of wait states and an
// optional mode in which pready never rises
// *********************************************************************

module apb_periph_model
  import periph_bus_pkg::*;
#(
  parameter int unsigned WAIT_STATES = 0,
  parameter bit          NEVER_READY = 1'b0
) (
  input  logic     clk_i,
  input  logic     rst_i,
  input  apb_req_t req_i,
  output apb_rsp_t rsp_o
);

  timeunit 1ns;
  timeprecision 1ps;

  logic [APB_DATA_WIDTH-1:0] mem_q [16];
  logic [7:0]                wait_q;
  logic [3:0]                word;
  logic                      access;
  logic                      ready;

  assign word   = req_i.paddr[5:2];
  assign access = req_i.psel && req_i.penable;
  assign ready  = access && !NEVER_READY && (wait_q == 8'(WAIT_STATES));

  // wait_q counts access cycles already spent and restarts for each transfer
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wait_q <= '0;
      for (int i = 0; i < 16; i++) begin
        mem_q[i] <= '0;
      end
    end else begin
      if (access && !ready) begin
        wait_q <= wait_q + 8'd1;
      end else begin
        wait_q <= '0;
      end
      if (ready && req_i.pwrite) begin
        mem_q[word] <= req_i.pwdata;
      end
    end
  end

  assign rsp_o.prdata  = (ready && !req_i.pwrite) ? mem_q[word] : '0;
  assign rsp_o.pready  = ready;
  assign rsp_o.pslverr = 1'b0;

endmodule

//--- design/periph_bus_wrap.sv
// *********************************************************************
// peripheral bus top level
// one APB completer port towards the system and NB_PERIPH requester
// ports towards the peripherals, with request-timeout supervision
// *********************************************************************

module periph_bus_wrap
  import periph_bus_pkg::*;
#(
  parameter int unsigned RTO_CYCLES = 16
) (
  input  logic                           clk_i,
  input  logic                           rst_i,

  // system side
  input  apb_req_t                       slv_req_i,
  output apb_rsp_t                       slv_rsp_o,

  // peripheral side
  output apb_req_t       [NB_PERIPH-1:0] mst_req_o,
  input  apb_rsp_t       [NB_PERIPH-1:0] mst_rsp_i,

  // one pulse per timed-out transfer, at the silent peripheral's index
  output logic           [NB_PERIPH-1:0] peripheral_rto_o
);

  logic start_rto;
  logic clr_rto;
  logic rto;

  // *******************************************************************
  // decode node
  // *******************************************************************

  apb_node #(
    .NB_MASTER  (NB_PERIPH),
    .ADDR_RULES (PERIPH_MAP)
  ) i_apb_node (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .slv_req_i        (slv_req_i),
    .slv_rsp_o        (slv_rsp_o),
    .mst_req_o        (mst_req_o),
    .mst_rsp_i        (mst_rsp_i),
    .rto_i            (rto),
    .start_rto_o      (start_rto),
    .clr_rto_o        (clr_rto),
    .peripheral_rto_o (peripheral_rto_o)
  );

  // *******************************************************************
  // timeout counter
  // *******************************************************************

  // the node arms it in the setup phase and clears it on a normal finish
  apb_rto_counter #(
    .RTO_CYCLES (RTO_CYCLES)
  ) i_apb_rto_counter (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .start_i (start_rto),
    .clr_i   (clr_rto),
    .rto_o   (rto)
  );

endmodule

//--- design/apb_node/apb_node.sv
// *********************************************************************
// APB node
// decodes each transfer against the window table, forwards it to one
// requester port and muxes the response back; unmapped addresses and
// peripherals that never answer are closed with an error
// *********************************************************************

module apb_node
  import periph_bus_pkg::*;
#(
  parameter int unsigned NB_MASTER = 4,
  parameter addr_rule_t  ADDR_RULES [NB_MASTER] = '{default: '0}
) (
  input  logic                           clk_i,
  input  logic                           rst_i,
  input  apb_req_t                       slv_req_i,
  output apb_rsp_t                       slv_rsp_o,
  output apb_req_t       [NB_MASTER-1:0] mst_req_o,
  input  apb_rsp_t       [NB_MASTER-1:0] mst_rsp_i,
  input  logic                           rto_i,
  output logic                           start_rto_o,
  output logic                           clr_rto_o,
  output logic           [NB_MASTER-1:0] peripheral_rto_o
);

  localparam int unsigned IDX_W = (NB_MASTER > 1) ? $clog2(NB_MASTER) : 1;

  logic [NB_MASTER-1:0] hit;
  logic                 any_hit;
  logic [IDX_W-1:0]     sel_idx;
  apb_rsp_t             sel_rsp;
  logic                 access_phase;
  logic                 rto_fire;
  logic                 access_q;

  // *******************************************************************
  // address decode
  // *******************************************************************

  // the windows never overlap, so at most one bit of hit is set
  always_comb begin
    hit     = '0;
    sel_idx = '0;
    for (int k = 0; k < NB_MASTER; k++) begin
      if ((slv_req_i.paddr >= ADDR_RULES[k].start_addr) &&
          (slv_req_i.paddr <= ADDR_RULES[k].end_addr)) begin
        hit[k]  = 1'b1;
        sel_idx = IDX_W'(k);
      end
    end
  end

  assign any_hit = |hit;

  // *******************************************************************
  // request fan-out and response mux
  // *******************************************************************

  always_comb begin
    for (int k = 0; k < NB_MASTER; k++) begin
      mst_req_o[k]      = slv_req_i;
      mst_req_o[k].psel = slv_req_i.psel && hit[k];
    end
  end

  assign sel_rsp      = mst_rsp_i[sel_idx];
  assign access_phase = slv_req_i.psel && slv_req_i.penable;

  // a timeout only matters while the selected peripheral is still stalling
  assign rto_fire = access_phase && any_hit && rto_i && !sel_rsp.pready;

  always_comb begin
    slv_rsp_o = '0;
    if (any_hit) begin
      slv_rsp_o.prdata  = sel_rsp.prdata;
      slv_rsp_o.pready  = access_phase && (sel_rsp.pready || rto_fire);
      slv_rsp_o.pslverr = access_phase && (sel_rsp.pready ? sel_rsp.pslverr : rto_fire);
    end else begin
      // nobody owns this address, so the node closes the access itself
      slv_rsp_o.pready  = access_phase;
      slv_rsp_o.pslverr = access_phase;
    end
  end

  // *******************************************************************
  // timeout control
  // *******************************************************************

  // set in the setup cycle, cleared once the upstream transfer completes
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      access_q <= 1'b0;
    end else begin
      access_q <= slv_req_i.psel && !(slv_req_i.penable && slv_rsp_o.pready);
    end
  end

  // only mapped transfers arm the counter
  assign start_rto_o = slv_req_i.psel && !access_q && any_hit;

  // a normal completion stops the counter before it can fire later
  assign clr_rto_o = access_phase && any_hit && sel_rsp.pready;

  always_comb begin
    for (int k = 0; k < NB_MASTER; k++) begin
      peripheral_rto_o[k] = rto_fire && (sel_idx == IDX_W'(k));
    end
  end

endmodule

//--- design/apb_node/apb_rto_counter.sv
// *********************************************************************
// APB request-timeout counter
// armed by a start pulse, counts down and flags a transfer that has
// waited RTO_CYCLES cycles; a clear pulse disarms it
// *********************************************************************

module apb_rto_counter #(
  parameter int unsigned RTO_CYCLES = 16
) (
  input  logic clk_i,
  input  logic rst_i,
  input  logic start_i,
  input  logic clr_i,
  output logic rto_o
);

  localparam int unsigned CNT_W = (RTO_CYCLES > 1) ? $clog2(RTO_CYCLES) : 1;

  logic [CNT_W-1:0] cnt_q;
  logic             armed_q;

  // start has priority over clear, and the counter disarms on expiry
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cnt_q   <= '0;
      armed_q <= 1'b0;
    end else if (start_i) begin
      cnt_q   <= CNT_W'(RTO_CYCLES - 1);
      armed_q <= 1'b1;
    end else if (clr_i || rto_o) begin
      armed_q <= 1'b0;
    end else if (armed_q) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  // the load value of RTO_CYCLES-1 puts expiry RTO_CYCLES cycles after setup
  assign rto_o = armed_q && (cnt_q == '0);

endmodule

//--- common/periph_bus_pkg.sv
// *********************************************************************
// peripheral bus package
// APB request and response structs, bus widths and the address map
// of the peripheral windows served by the SoC peripheral node
// *********************************************************************

package periph_bus_pkg;

  // *******************************************************************
  // bus widths
  // *******************************************************************

  localparam int unsigned APB_ADDR_WIDTH = 32;
  localparam int unsigned APB_DATA_WIDTH = 32;

  // number of peripheral windows in the map
  localparam int unsigned NB_PERIPH = 4;

  // *******************************************************************
  // APB payload
  // *******************************************************************

  // request from the requester side, 67 bits
  typedef struct packed {
    logic [APB_ADDR_WIDTH-1:0] paddr;
    logic                      pwrite;
    logic                      psel;
    logic                      penable;
    logic [APB_DATA_WIDTH-1:0] pwdata;
  } apb_req_t;

  // response from the completer side, 34 bits
  typedef struct packed {
    logic [APB_DATA_WIDTH-1:0] prdata;
    logic                      pready;
    logic                      pslverr;
  } apb_rsp_t;

  // one address window, end_addr is inclusive
  typedef struct packed {
    logic [APB_ADDR_WIDTH-1:0] start_addr;
    logic [APB_ADDR_WIDTH-1:0] end_addr;
  } addr_rule_t;

  // *******************************************************************
  // peripheral address map
  // *******************************************************************

  // entry order is the peripheral index: gpio, timer, soc_ctrl, stdout
  localparam addr_rule_t PERIPH_MAP [NB_PERIPH] = '{
    '{start_addr: 32'h1A10_1000, end_addr: 32'h1A10_1FFF},
    '{start_addr: 32'h1A10_2000, end_addr: 32'h1A10_2FFF},
    '{start_addr: 32'h1A10_4000, end_addr: 32'h1A10_4FFF},
    '{start_addr: 32'h1A10_F000, end_addr: 32'h1A10_FFFF}
  };

endpackage
